// File: compile.f
isa_pkg.sv
pipe_pkg.sv
fetch_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
pipeline_cpu.sv
cpu_props.sv
tb_pipeline_cpu.sv

// File: cpu_props.sv
module cpu_props (
    input logic           clk,
    input logic           rst,
    input logic           cpu_en,
    input isa_pkg::word_t pc,
    input logic           mem_we
);
    timeunit 1ns;
    timeprecision 100ps;

    // valid bits are cleared by reset
    assert property (@(posedge clk) rst |=> !mem_we)
        else $error("mem_we high in the cycle after reset");

    assert property (@(posedge clk) !cpu_en && !rst |=> $stable(pc))
        else $error("pc moved while cpu_en was low");

    assert property (@(posedge clk) disable iff (rst) !$isunknown(mem_we))
        else $error("mem_we is unknown");

endmodule

bind pipeline_cpu cpu_props props0 (
    .clk    (clk),
    .rst    (rst),
    .cpu_en (cpu_en),
    .pc     (pc),
    .mem_we (mem_we)
);

// File: decode_stage.sv
module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_en,
    input  pipe_pkg::if_id_t   if_id,
    input  logic               flush,
    input  isa_pkg::reg_addr_t ex_mem_dest,
    input  logic               ex_mem_reg_we,
    input  logic               wb_we,
    input  isa_pkg::reg_addr_t wb_dest,
    input  isa_pkg::word_t     wb_data,
    output pipe_pkg::id_ex_t   id_ex,
    output logic               stall
);

    isa_pkg::opcode_e   opcode;
    isa_pkg::funct_e    funct;
    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     rs_val;
    isa_pkg::word_t     rt_val;
    isa_pkg::word_t     imm_sext;
    isa_pkg::word_t     shamt_ext;
    logic               is_shift;
    logic               uses_rs;
    logic               uses_rt;
    logic               ex_writes;
    logic               hz_rs;
    logic               hz_rt;
    pipe_pkg::id_ex_t   id_ex_d;

    assign opcode = isa_pkg::opcode_e'(if_id.instr[31:26]);
    assign funct  = isa_pkg::funct_e'(if_id.instr[5:0]);
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];

    assign imm_sext  = {{(isa_pkg::WORD_W - isa_pkg::IMM_W){if_id.instr[isa_pkg::IMM_W-1]}},
                        if_id.instr[isa_pkg::IMM_W-1:0]};
    assign shamt_ext = {{(isa_pkg::WORD_W - isa_pkg::SHAMT_W){1'b0}}, if_id.instr[10:6]};

    reg_file u_reg_file (
        .clk     (clk),
        .we      (wb_we),
        .waddr   (wb_dest),
        .wdata   (wb_data),
        .raddr_a (rs),
        .raddr_b (rt),
        .rdata_a (rs_val),
        .rdata_b (rt_val)
    );

    // which sources the instruction really reads
    assign is_shift = (opcode == isa_pkg::OP_RTYPE) &&
                      (funct == isa_pkg::FN_SLL || funct == isa_pkg::FN_SRL);
    assign uses_rs  = (opcode == isa_pkg::OP_RTYPE && !is_shift) ||
                      opcode == isa_pkg::OP_ADDI || opcode == isa_pkg::OP_LW ||
                      opcode == isa_pkg::OP_SW   || opcode == isa_pkg::OP_BEQ;
    assign uses_rt  = opcode == isa_pkg::OP_RTYPE || opcode == isa_pkg::OP_SW ||
                      opcode == isa_pkg::OP_BEQ;

    // no forwarding, wait until the producer reaches writeback
    assign ex_writes = id_ex.valid & id_ex.reg_we;
    assign hz_rs = uses_rs && rs != '0 &&
                   ((ex_writes && rs == id_ex.dest) || (ex_mem_reg_we && rs == ex_mem_dest));
    assign hz_rt = uses_rt && rt != '0 &&
                   ((ex_writes && rt == id_ex.dest) || (ex_mem_reg_we && rt == ex_mem_dest));
    assign stall = if_id.valid & (hz_rs | hz_rt);

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.valid      = if_id.valid & ~stall & ~flush;
        id_ex_d.operand_a  = rs_val;
        id_ex_d.operand_b  = imm_sext;
        id_ex_d.store_data = rt_val;
        id_ex_d.alu_op     = isa_pkg::ALU_ADD;
        case (opcode)
            isa_pkg::OP_RTYPE: begin
                id_ex_d.operand_b = rt_val;
                id_ex_d.dest      = rd;
                id_ex_d.reg_we    = 1'b1;
                case (funct)
                    isa_pkg::FN_ADD: id_ex_d.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: id_ex_d.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND: id_ex_d.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:  id_ex_d.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT: id_ex_d.alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::FN_SLL: begin
                        id_ex_d.alu_op    = isa_pkg::ALU_SLL;
                        id_ex_d.operand_a = shamt_ext;
                    end
                    isa_pkg::FN_SRL: begin
                        id_ex_d.alu_op    = isa_pkg::ALU_SRL;
                        id_ex_d.operand_a = shamt_ext;
                    end
                    default: id_ex_d.reg_we = 1'b0;  // unknown funct runs as nop
                endcase
            end
            isa_pkg::OP_ADDI: begin
                id_ex_d.dest   = rt;
                id_ex_d.reg_we = 1'b1;
            end
            isa_pkg::OP_LW: begin
                id_ex_d.dest       = rt;
                id_ex_d.reg_we     = 1'b1;
                id_ex_d.mem_to_reg = 1'b1;
            end
            isa_pkg::OP_SW: id_ex_d.mem_we = 1'b1;
            isa_pkg::OP_BEQ: begin
                id_ex_d.redirect = (rs_val == rt_val);
                id_ex_d.target   = if_id.pc_4 + (imm_sext << 2);
            end
            isa_pkg::OP_J: begin
                id_ex_d.redirect = 1'b1;
                id_ex_d.target   = {if_id.pc_4[isa_pkg::WORD_W-1:isa_pkg::JADDR_W+2],
                                    if_id.instr[isa_pkg::JADDR_W-1:0], 2'b00};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid    <= 1'b0;
            id_ex.reg_we   <= 1'b0;
            id_ex.mem_we   <= 1'b0;
            id_ex.redirect <= 1'b0;
        end else if (cpu_en) begin
            id_ex <= id_ex_d;
        end
    end

endmodule

// File: execute_stage.sv
module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_en,
    input  pipe_pkg::id_ex_t  id_ex,
    output logic              redirect,
    output isa_pkg::word_t    target,
    output pipe_pkg::ex_mem_t ex_mem,
    output logic              mem_we
);

    isa_pkg::word_t                    alu_result;
    logic [isa_pkg::SHAMT_W-1:0]       shamt;
    pipe_pkg::ex_mem_t                 ex_mem_d;

    assign shamt = id_ex.operand_a[isa_pkg::SHAMT_W-1:0];

    always_comb begin
        case (id_ex.alu_op)
            isa_pkg::ALU_ADD: alu_result = id_ex.operand_a + id_ex.operand_b;
            isa_pkg::ALU_SUB: alu_result = id_ex.operand_a - id_ex.operand_b;
            isa_pkg::ALU_AND: alu_result = id_ex.operand_a & id_ex.operand_b;
            isa_pkg::ALU_OR:  alu_result = id_ex.operand_a | id_ex.operand_b;
            isa_pkg::ALU_SLT: begin
                alu_result = isa_pkg::word_t'($signed(id_ex.operand_a) <
                                              $signed(id_ex.operand_b));
            end
            isa_pkg::ALU_SLL: alu_result = id_ex.operand_b << shamt;
            isa_pkg::ALU_SRL: alu_result = id_ex.operand_b >> shamt;  // logical
            default:          alu_result = '0;
        endcase
    end

    // branch resolved in decode, taken here
    assign redirect = id_ex.valid & id_ex.redirect;
    assign target   = id_ex.target;

    always_comb begin
        ex_mem_d.valid      = id_ex.valid;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = id_ex.store_data;
        ex_mem_d.dest       = id_ex.dest;
        ex_mem_d.reg_we     = id_ex.valid & id_ex.reg_we;
        ex_mem_d.mem_we     = id_ex.valid & id_ex.mem_we;
        ex_mem_d.mem_to_reg = id_ex.mem_to_reg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid  <= 1'b0;
            ex_mem.reg_we <= 1'b0;
            ex_mem.mem_we <= 1'b0;
        end else if (cpu_en) begin
            ex_mem <= ex_mem_d;
        end
    end

    // no store while frozen
    assign mem_we = ex_mem.valid & ex_mem.mem_we & cpu_en;

endmodule

// File: fetch_unit.sv
module fetch_unit #(
    parameter isa_pkg::word_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_en,
    input  logic             stall,
    input  logic             redirect,
    input  isa_pkg::word_t   target,
    input  isa_pkg::word_t   instr,
    output isa_pkg::word_t   pc,
    output pipe_pkg::if_id_t if_id
);

    isa_pkg::word_t pc_4;
    isa_pkg::word_t next_pc;

    assign pc_4 = pc + 32'd4;

    // redirect wins over a decode stall
    always_comb begin
        if (redirect) begin
            next_pc = target;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc_4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (cpu_en) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id.valid <= 1'b0;
        end else if (cpu_en) begin
            if (redirect) begin
                if_id.valid <= 1'b0;  // squash the younger fetch
            end else if (!stall) begin
                if_id.valid <= 1'b1;
                if_id.pc_4  <= pc_4;
                if_id.instr <= instr;
            end
        end
    end

endmodule

// File: isa_pkg.sv
package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int JADDR_W    = 26;
    localparam int ALU_OP_W   = 4;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // primary opcode, instr[31:26]
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // r-type function field, instr[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6
    } alu_op_e;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc_4;
        isa_pkg::word_t instr;
    } if_id_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     operand_a;
        isa_pkg::word_t     operand_b;
        isa_pkg::word_t     store_data;  // rt value for sw
        isa_pkg::alu_op_e   alu_op;
        isa_pkg::reg_addr_t dest;
        logic               reg_we;
        logic               mem_we;
        logic               mem_to_reg;
        logic               redirect;    // taken beq or j
        isa_pkg::word_t     target;
    } id_ex_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     alu_result;
        isa_pkg::word_t     store_data;
        isa_pkg::reg_addr_t dest;
        logic               reg_we;
        logic               mem_we;
        logic               mem_to_reg;
    } ex_mem_t;

    // load data captured alongside the alu result
    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     alu_result;
        isa_pkg::word_t     load_data;
        isa_pkg::reg_addr_t dest;
        logic               reg_we;
        logic               mem_to_reg;
    } mem_wb_t;

endpackage

// File: pipeline_cpu.sv
module pipeline_cpu #(
    parameter isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           cpu_en,
    input  isa_pkg::word_t instr,
    input  isa_pkg::word_t data_in,
    output isa_pkg::word_t pc,
    output isa_pkg::word_t mem_addr,
    output isa_pkg::word_t mem_wdata,
    output logic           mem_we
);

    pipe_pkg::if_id_t   if_id;
    pipe_pkg::id_ex_t   id_ex;
    pipe_pkg::ex_mem_t  ex_mem;
    logic               stall;
    logic               redirect;
    isa_pkg::word_t     target;
    logic               wb_we;
    isa_pkg::reg_addr_t wb_dest;
    isa_pkg::word_t     wb_data;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst      (rst),
        .cpu_en   (cpu_en),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .instr    (instr),
        .pc       (pc),
        .if_id    (if_id)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst           (rst),
        .cpu_en        (cpu_en),
        .if_id         (if_id),
        .flush         (redirect),
        .ex_mem_dest   (ex_mem.dest),
        .ex_mem_reg_we (ex_mem.reg_we),  // already qualified by valid
        .wb_we         (wb_we),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data),
        .id_ex         (id_ex),
        .stall         (stall)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst      (rst),
        .cpu_en   (cpu_en),
        .id_ex    (id_ex),
        .redirect (redirect),
        .target   (target),
        .ex_mem   (ex_mem),
        .mem_we   (mem_we)
    );

    // memory stage is the data ram itself
    assign mem_addr  = ex_mem.alu_result;
    assign mem_wdata = ex_mem.store_data;

    writeback_stage u_writeback (
        .clk     (clk),
        .rst     (rst),
        .cpu_en  (cpu_en),
        .ex_mem  (ex_mem),
        .data_in (data_in),
        .wb_we   (wb_we),
        .wb_dest (wb_dest),
        .wb_data (wb_data)
    );

endmodule

// File: reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               we,
    input  isa_pkg::reg_addr_t waddr,
    input  isa_pkg::word_t     wdata,
    input  isa_pkg::reg_addr_t raddr_a,
    input  isa_pkg::reg_addr_t raddr_b,
    output isa_pkg::word_t     rdata_a,
    output isa_pkg::word_t     rdata_b
);

    isa_pkg::word_t regs [1:31];  // r0 not stored

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // writeback value bypasses straight to a same-cycle read
    assign rdata_a = (raddr_a == '0)                 ? '0    :
                     (we && waddr == raddr_a)        ? wdata :
                                                       regs[raddr_a];
    assign rdata_b = (raddr_b == '0)                 ? '0    :
                     (we && waddr == raddr_b)        ? wdata :
                                                       regs[raddr_b];

endmodule

// File: tb_pipeline_cpu.sv
module tb_pipeline_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam isa_pkg::word_t RESET_PC = 32'h0000_0100;
    localparam int MEM_WORDS = 256;
    localparam int BASE = RESET_PC / 4;

    logic           clk;
    logic           rst;
    logic           cpu_en;
    isa_pkg::word_t instr;
    isa_pkg::word_t data_in;
    isa_pkg::word_t pc;
    isa_pkg::word_t mem_addr;
    isa_pkg::word_t mem_wdata;
    logic           mem_we;

    isa_pkg::word_t rom [0:MEM_WORDS-1];
    isa_pkg::word_t ram [0:MEM_WORDS-1];
    isa_pkg::word_t exp_addr [0:63];
    isa_pkg::word_t exp_data [0:63];
    int             prog_len;
    int             exp_count;
    int             st_idx;
    int             cycles;
    int             budget;
    integer         seed = 61063;
    bit             after_reset;
    bit             prev_hold;
    isa_pkg::word_t prev_pc;

    pipeline_cpu #(.RESET_PC(RESET_PC)) dut0 (.*);

    assign instr   = rom[pc[9:2]];
    assign data_in = ram[mem_addr[9:2]];

    function automatic isa_pkg::word_t fill_word(int idx);
        isa_pkg::word_t a;
        a = idx * 4;
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    // ram comes back to its fill pattern on every reset
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                ram[i] <= fill_word(i);
            end
        end else if (mem_we) begin
            ram[mem_addr[9:2]] <= mem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input isa_pkg::word_t got,
                             input isa_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic isa_pkg::word_t r_op(isa_pkg::funct_e fn, int rd, int rs, int rt, int sh);
        return {isa_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic isa_pkg::word_t i_op(isa_pkg::opcode_e op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic isa_pkg::word_t here();
        return RESET_PC + 4 * prog_len;
    endfunction

    task automatic emit(input isa_pkg::word_t w);
        rom[BASE + prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        emit(i_op(isa_pkg::OP_ADDI, 1, 0, $random(seed)));
        emit(i_op(isa_pkg::OP_ADDI, 2, 0, $random(seed)));
        emit(r_op(isa_pkg::FN_ADD, 3, 1, 2, 0));
        emit(r_op(isa_pkg::FN_SUB, 4, 1, 2, 0));
        emit(r_op(isa_pkg::FN_AND, 5, 1, 2, 0));
        emit(r_op(isa_pkg::FN_OR, 6, 1, 2, 0));
        emit(r_op(isa_pkg::FN_SLT, 7, 1, 2, 0));
        emit(r_op(isa_pkg::FN_SLT, 8, 2, 1, 0));
        emit(r_op(isa_pkg::FN_SLL, 9, 0, 1, $random(seed)));
        emit(r_op(isa_pkg::FN_SRL, 10, 0, 2, $random(seed)));
        emit(i_op(isa_pkg::OP_ADDI, 11, 1, $random(seed)));
        for (int r = 3; r <= 11; r++) begin
            emit(i_op(isa_pkg::OP_SW, r, 0, 4 * r));
        end
        emit(i_op(isa_pkg::OP_ADDI, 12, 3, $random(seed)));
        emit(r_op(isa_pkg::FN_SUB, 13, 12, 4, 0));         // back to back on r12
        emit(i_op(isa_pkg::OP_ADDI, 14, 0, $random(seed)));
        emit(r_op(isa_pkg::FN_OR, 15, 13, 14, 0));         // r13 at distance two
        emit(i_op(isa_pkg::OP_SW, 15, 0, 32'h40));
        emit(i_op(isa_pkg::OP_LW, 16, 0, 32'h80));
        emit(r_op(isa_pkg::FN_ADD, 17, 16, 15, 0));        // load-use
        emit(i_op(isa_pkg::OP_SW, 17, 0, 32'h44));
        emit(i_op(isa_pkg::OP_LW, 18, 0, 32'h44));         // reads back the store
        emit(r_op(isa_pkg::FN_ADD, 19, 18, 16, 0));
        emit(i_op(isa_pkg::OP_SW, 19, 0, 32'h48));
        // squashed slots hold stores
        emit(i_op(isa_pkg::OP_ADDI, 20, 0, 5));
        emit(i_op(isa_pkg::OP_BEQ, 20, 20, 2));            // taken
        emit(i_op(isa_pkg::OP_SW, 1, 0, 32'hc0));
        emit(i_op(isa_pkg::OP_SW, 2, 0, 32'hc4));
        emit(i_op(isa_pkg::OP_BEQ, 0, 20, 1));             // not taken
        emit(i_op(isa_pkg::OP_SW, 20, 0, 32'hc8));
        emit({isa_pkg::OP_J, 26'((here() + 12) >> 2)});
        emit(i_op(isa_pkg::OP_SW, 1, 0, 32'hcc));
        emit(i_op(isa_pkg::OP_SW, 2, 0, 32'hd0));
        emit(i_op(isa_pkg::OP_SW, 13, 0, 32'hd4));
        emit({isa_pkg::OP_J, 26'(here() >> 2)});           // park on itself
    endtask

    // steps the program one instruction at a time and records each store
    function automatic int ref_run();
        isa_pkg::word_t regs [0:31];
        isa_pkg::word_t dmem [0:MEM_WORDS-1];
        isa_pkg::word_t cur;
        isa_pkg::word_t ins;
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t imm;
        isa_pkg::word_t addr;
        isa_pkg::word_t nxt;
        int             steps;
        bit             done;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(i);
        end
        cur = RESET_PC;
        steps = 0;
        done = 1'b0;
        exp_count = 0;
        while (!done && steps < 2000) begin
            ins  = rom[cur[9:2]];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            nxt  = cur + 4;
            steps++;
            case (ins[31:26])
                isa_pkg::OP_RTYPE: begin
                    case (ins[5:0])
                        isa_pkg::FN_ADD: regs[ins[15:11]] = a + b;
                        isa_pkg::FN_SUB: regs[ins[15:11]] = a - b;
                        isa_pkg::FN_AND: regs[ins[15:11]] = a & b;
                        isa_pkg::FN_OR:  regs[ins[15:11]] = a | b;
                        isa_pkg::FN_SLT: regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                        isa_pkg::FN_SLL: regs[ins[15:11]] = b << ins[10:6];
                        isa_pkg::FN_SRL: regs[ins[15:11]] = b >> ins[10:6];
                        default: ;
                    endcase
                end
                isa_pkg::OP_ADDI: regs[ins[20:16]] = addr;
                isa_pkg::OP_LW:   regs[ins[20:16]] = dmem[addr[9:2]];
                isa_pkg::OP_SW: begin
                    dmem[addr[9:2]] = b;
                    exp_addr[exp_count] = addr;
                    exp_data[exp_count] = b;
                    exp_count++;
                end
                isa_pkg::OP_BEQ: begin
                    if (a == b) begin
                        nxt = cur + 4 + (imm << 2);
                    end
                end
                isa_pkg::OP_J: begin
                    nxt  = {nxt[31:28], ins[25:0], 2'b00};
                    done = (nxt == cur);
                end
                default: ;
            endcase
            regs[0] = '0;
            cur = nxt;
        end
        return steps;
    endfunction

    // rst held over two rising edges
    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(negedge clk);
        st_idx = 0;
        cycles = 0;
        rst = 1'b0;
    endtask

    task automatic run_program(input bit pulse_en, input int reset_at);
        int low_left;
        bit did_reset;
        low_left = 0;
        did_reset = 1'b0;
        @(negedge clk);
        cpu_en = 1'b1;
        apply_reset();
        while (st_idx < exp_count) begin
            @(negedge clk);
            if (reset_at > 0 && !did_reset && st_idx >= reset_at) begin
                did_reset = 1'b1;
                apply_reset();
            end else if (pulse_en && low_left > 0) begin
                low_left--;
                cpu_en = 1'b0;
            end else if (pulse_en && ($random(seed) & 7) == 0) begin
                low_left = $random(seed) & 3;
                cpu_en = 1'b0;
            end else begin
                cpu_en = 1'b1;
            end
        end
        @(negedge clk);
        cpu_en = 1'b1;
        repeat (20) @(negedge clk);  // room for a stray store
    endtask

    always @(posedge clk) begin
        if (after_reset) begin
            check_val("mem_we", {31'b0, mem_we}, '0);
        end
        if (prev_hold) begin
            check_val("pc", pc, prev_pc);
        end
        if (!rst) begin
            if ($isunknown(mem_we)) begin
                abort_run("mem_we went unknown after reset");
            end
            if (mem_we) begin
                if (!cpu_en) begin
                    abort_run("a store was issued while cpu_en was low");
                end
                if (st_idx >= exp_count) begin
                    abort_run("a store appeared after the last expected store");
                end
                check_val("mem_addr", mem_addr, exp_addr[st_idx]);
                check_val("mem_wdata", mem_wdata, exp_data[st_idx]);
                st_idx++;
            end
        end
        after_reset = rst;
        prev_hold = !cpu_en && !rst;
        prev_pc = pc;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > budget) begin
                abort_run("timeout, the expected stores did not all appear in time");
            end
        end
    end

    initial begin
        rst = 1'b1;
        cpu_en = 1'b1;
        cycles = 0;
        st_idx = 0;
        prog_len = 0;
        after_reset = 1'b0;
        prev_hold = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = '0;  // sll r0 acts as nop
        end
        build_program();
        budget = ref_run() * 6 + 50;
        run_program(1'b0, 0);
        run_program(1'b1, 0);
        run_program(1'b0, 6);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: writeback_stage.sv
module writeback_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_en,
    input  pipe_pkg::ex_mem_t  ex_mem,
    input  isa_pkg::word_t     data_in,
    output logic               wb_we,
    output isa_pkg::reg_addr_t wb_dest,
    output isa_pkg::word_t     wb_data
);

    pipe_pkg::mem_wb_t mem_wb;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid  <= 1'b0;
            mem_wb.reg_we <= 1'b0;
        end else if (cpu_en) begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= data_in;  // ram read at the memory-stage address
            mem_wb.dest       <= ex_mem.dest;
            mem_wb.reg_we     <= ex_mem.reg_we;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
        end
    end

    assign wb_we   = mem_wb.valid & mem_wb.reg_we & cpu_en;
    assign wb_dest = mem_wb.dest;
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule
